/* src/lwc_api_pkg.sv */
/*
 * External LWC API word format for a 32-bit PDI/DO bus.
 * Only encrypt and decrypt opcodes are recognised; any other opcode is ignored.
 * Segment length is the 16-bit byte count in the low half of a header word.
 */
`default_nettype none

package lwc_api_pkg;

    // One PDI or DO bus word
    typedef logic [31:0] lwc_word_t;

    // Instruction opcodes, top nibble of the instruction word
    typedef enum logic [3:0] {
        OP_ENC = 4'b0010,
        OP_DEC = 4'b0011
    } lwc_opcode_t;

    // Segment types, top nibble of a header or status word
    typedef enum logic [3:0] {
        SEG_PLAINTEXT  = 4'b0100,
        SEG_CIPHERTEXT = 4'b0101,
        SEG_STATUS_OK  = 4'b1110
    } lwc_seg_type_t;

    // Opcode and segment type share the same nibble
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;

    // End-of-type flag inside a segment header
    localparam int HDR_EOT_BIT = 25;

    // Length field occupies bits HDR_LEN_BITS-1 down to 0
    localparam int HDR_LEN_BITS = 16;

    typedef logic [HDR_LEN_BITS-1:0] lwc_len_t;

    localparam int BYTES_PER_WORD = 4;

endpackage

`default_nettype wire

/* src/lwc_wrapper_pkg.sv */
/*
 * Entry format passed from the PDI parser through the FIFO to the DO formatter.
 * A header entry carries the raw input header word; eot and length are taken from it.
 */
`default_nettype none

package lwc_wrapper_pkg;

    typedef enum logic [1:0] {
        KIND_HEADER = 2'd0,
        KIND_DATA   = 2'd1,
        KIND_END    = 2'd2
    } entry_kind_t;

    // Valid bytes in a data word, 1 to 4
    typedef logic [2:0] byte_cnt_t;

    localparam int ENTRY_BITS = 40;

    // Field order from the top; spare is always zero
    typedef struct packed {
        logic        spare;
        entry_kind_t kind;
        logic        dec;
        byte_cnt_t   cnt;
        logic        seg_last;
        logic [31:0] word;
    } lwc_entry_t;

endpackage

`default_nettype wire

/* src/lwc_pdi_parser.sv */
/*
 * Splits the PDI stream into tagged entries, at most one per accepted word.
 * Words with an unknown opcode are consumed while waiting for an instruction.
 * The PDI source must hold pdi_data steady while pdi_valid is high and not accepted.
 */
`default_nettype none

module lwc_pdi_parser
    import lwc_api_pkg::*;
    import lwc_wrapper_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire lwc_word_t             pdi_data,
    input  wire logic                  pdi_valid,
    output logic                       pdi_ready,
    output logic [ENTRY_BITS-1:0]      push_entry,
    output logic                       push_valid,
    input  wire logic                  push_ready
);

    typedef enum logic [1:0] {
        ST_INST,
        ST_HEADER,
        ST_DATA,
        ST_END
    } state_t;

    state_t      state;
    logic        dec_flag;
    logic        eot_flag;
    lwc_len_t    remain;

    lwc_opcode_t opcode;
    lwc_len_t    hdr_len;
    logic        hdr_eot;
    logic        last_word;
    logic        pdi_fire;
    lwc_entry_t  entry;

    assign opcode    = lwc_opcode_t'(pdi_data[OPCODE_MSB:OPCODE_LSB]);
    assign hdr_len   = pdi_data[HDR_LEN_BITS-1:0];
    assign hdr_eot   = pdi_data[HDR_EOT_BIT];
    assign last_word = (remain <= lwc_len_t'(BYTES_PER_WORD));
    assign pdi_fire  = pdi_valid && pdi_ready;

    always_comb begin
        entry      = '0;
        entry.dec  = dec_flag;
        entry.word = pdi_data;
        push_valid = 1'b0;
        pdi_ready  = 1'b0;
        case (state)
            ST_INST: begin
                pdi_ready = push_ready;
            end
            ST_HEADER: begin
                pdi_ready  = push_ready;
                push_valid = pdi_valid;
                entry.kind = KIND_HEADER;
            end
            ST_DATA: begin
                pdi_ready      = push_ready;
                push_valid     = pdi_valid;
                entry.kind     = KIND_DATA;
                entry.seg_last = last_word;
                if (last_word) begin
                    entry.cnt = byte_cnt_t'(remain);
                end else begin
                    entry.cnt = byte_cnt_t'(BYTES_PER_WORD);
                end
            end
            default: begin
                // Status marker, no PDI word taken
                push_valid = 1'b1;
                entry.kind = KIND_END;
                entry.word = '0;
            end
        endcase
    end

    assign push_entry = entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_INST;
            dec_flag <= 1'b0;
            eot_flag <= 1'b0;
            remain   <= '0;
        end else begin
            case (state)
                ST_INST: begin
                    if (pdi_fire && (opcode == OP_ENC || opcode == OP_DEC)) begin
                        dec_flag <= (opcode == OP_DEC);
                        state    <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (pdi_fire) begin
                        remain   <= hdr_len;
                        eot_flag <= hdr_eot;
                        if (hdr_len != '0) begin
                            state <= ST_DATA;
                        end else if (hdr_eot) begin
                            state <= ST_END;
                        end
                    end
                end
                ST_DATA: begin
                    if (pdi_fire) begin
                        if (last_word) begin
                            remain <= '0;
                            state  <= eot_flag ? ST_END : ST_HEADER;
                        end else begin
                            remain <= remain - lwc_len_t'(BYTES_PER_WORD);
                        end
                    end
                end
                default: begin
                    if (push_ready) begin
                        state <= ST_INST;
                    end
                end
            endcase
        end
    end

    // An offered entry must wait unchanged for the FIFO
    a_push_hold: assert property (@(posedge clk) disable iff (rst)
        push_valid && !push_ready |=> push_valid && $stable(push_entry))
        else $error("parser entry changed while stalled");

endmodule

`default_nettype wire

/* src/lwc_entry_fifo.sv */
/*
 * Synchronous FIFO of parser entries, FIFO_DEPTH must be a power of two, 2 or more.
 * push_ready is registered and low during reset; pop_valid shows the head entry.
 */
`default_nettype none

module lwc_entry_fifo
    import lwc_wrapper_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [ENTRY_BITS-1:0] push_entry,
    input  wire logic                  push_valid,
    output logic                       push_ready,
    output logic [ENTRY_BITS-1:0]      pop_entry,
    output logic                       pop_valid,
    input  wire logic                  pop_ready
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [ENTRY_BITS-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [AW:0]           count;
    logic [AW:0]           count_next;
    logic                  do_push;
    logic                  do_pop;

    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;
    assign count_next = count + (AW+1)'(do_push) - (AW+1)'(do_pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            push_ready <= 1'b0;
        end else begin
            count      <= count_next;
            push_ready <= (count_next != (AW+1)'(FIFO_DEPTH));
            if (do_push) begin
                wr_ptr <= AW'(wr_ptr + 1'b1);
            end
            if (do_pop) begin
                rd_ptr <= AW'(rd_ptr + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign pop_entry = mem[rd_ptr];
    assign pop_valid = (count != '0);

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        count <= (AW+1)'(FIFO_DEPTH))
        else $error("entry FIFO overflow");

    // Pointers must still hold data whenever an entry leaves
    a_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        do_pop |-> (rd_ptr != wr_ptr) || (count == (AW+1)'(FIFO_DEPTH)))
        else $error("entry FIFO popped while empty");

endmodule

`default_nettype wire

/* src/lwc_do_formatter.sv */
/*
 * Combinational DO word builder, no storage and no added latency.
 * do_valid follows the FIFO head, so do_data is only meaningful while do_valid is high.
 */
`default_nettype none

module lwc_do_formatter
    import lwc_api_pkg::*;
    import lwc_wrapper_pkg::*;
(
    input  wire logic [ENTRY_BITS-1:0] pop_entry,
    input  wire logic                  pop_valid,
    output logic                       pop_ready,
    output lwc_word_t                  do_data,
    output logic                       do_valid,
    input  wire logic                  do_ready,
    output logic                       do_last
);

    lwc_entry_t    ent;
    lwc_seg_type_t out_type;
    logic          hdr_eot;

    assign ent     = pop_entry;
    assign hdr_eot = ent.word[HDR_EOT_BIT];

    // Null cipher, so encrypt yields ciphertext and decrypt plaintext
    assign out_type = ent.dec ? SEG_PLAINTEXT : SEG_CIPHERTEXT;

    assign do_valid  = pop_valid;
    assign pop_ready = do_ready;

    always_comb begin
        do_data = '0;
        do_last = 1'b0;
        case (ent.kind)
            KIND_HEADER: begin
                do_data[OPCODE_MSB:OPCODE_LSB]  = out_type;
                do_data[27:24]                  = {2'b00, hdr_eot, ent.dec & hdr_eot};
                do_data[HDR_LEN_BITS-1:0]       = ent.word[HDR_LEN_BITS-1:0];
            end
            KIND_DATA: begin
                // Keep bytes from the top down, zero the unused tail
                for (int i = 0; i < BYTES_PER_WORD; i++) begin
                    if (i < int'(ent.cnt)) begin
                        do_data[31-8*i -: 8] = ent.word[31-8*i -: 8];
                    end
                end
            end
            KIND_END: begin
                do_data[OPCODE_MSB:OPCODE_LSB] = SEG_STATUS_OK;
                do_last                        = pop_valid;
            end
            default: begin
                do_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/lwc_null_wrapper.sv */
/*
 * LWC API framing wrapper around an identity cipher core, no SDI key bus.
 * Every ENC or DEC instruction ends in a success status word with do_last high.
 * FIFO_DEPTH must be a power of two, 2 or more.
 */
`default_nettype none

module lwc_null_wrapper
    import lwc_api_pkg::*;
    import lwc_wrapper_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire lwc_word_t pdi_data,
    input  wire logic      pdi_valid,
    output logic           pdi_ready,
    output lwc_word_t      do_data,
    output logic           do_valid,
    input  wire logic      do_ready,
    output logic           do_last
);

    logic [ENTRY_BITS-1:0] push_entry;
    logic                  push_valid;
    logic                  push_ready;
    logic [ENTRY_BITS-1:0] pop_entry;
    logic                  pop_valid;
    logic                  pop_ready;

    lwc_pdi_parser u_parser (
        .clk        (clk),
        .rst        (rst),
        .pdi_data   (pdi_data),
        .pdi_valid  (pdi_valid),
        .pdi_ready  (pdi_ready),
        .push_entry (push_entry),
        .push_valid (push_valid),
        .push_ready (push_ready)
    );

    lwc_entry_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_entry (push_entry),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_entry  (pop_entry),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    lwc_do_formatter u_formatter (
        .pop_entry (pop_entry),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_ready  (do_ready),
        .do_last   (do_last)
    );

    // DO word held across FIFO and formatter while the sink stalls
    a_do_stable: assert property (@(posedge clk) disable iff (rst)
        do_valid && !do_ready |=> do_valid && $stable(do_data) && $stable(do_last))
        else $error("DO output changed while stalled");

endmodule

`default_nettype wire

/* verification/tb_lwc_model.svh */
/*
 * Stimulus builder and reference model for the null-cipher wrapper testbench.
 * Included inside the testbench module and uses its lwc_api_pkg import.
 */
`ifndef TB_LWC_MODEL_SVH
`define TB_LWC_MODEL_SVH

int unsigned lcg_state = 10187;

lwc_word_t pdi_q[$];
lwc_word_t exp_word_q[$];
logic      exp_last_q[$];

function int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Upper bits only, the low LCG bits repeat quickly
function automatic int unsigned lcg_range(input int unsigned n);
    return (lcg_next() >> 8) % n;
endfunction

function automatic lwc_word_t rand_word();
    logic [15:0] hi;
    logic [15:0] lo;
    hi = 16'(lcg_next() >> 16);
    lo = 16'(lcg_next() >> 16);
    return {hi, lo};
endfunction

// Appends one instruction to pdi_q and its expected DO words to the model queues
task automatic build_instruction();
    logic       dec;
    logic       eot;
    logic [3:0] op;
    int         nseg;
    int         len;
    int         left;
    int         cnt;
    lwc_word_t  w;
    lwc_word_t  keep;
    w = rand_word();
    if (lcg_range(10) == 0) begin
        // Skip opcodes 2 and 3
        op = 4'(lcg_range(14));
        if (op >= 4'd2) begin
            op = op + 4'd2;
        end
        pdi_q.push_back({op, w[27:0]});
    end else begin
        dec = (lcg_range(2) == 1);
        pdi_q.push_back({dec ? OP_DEC : OP_ENC, w[27:0]});
        nseg = 1 + lcg_range(3);
        for (int s = 0; s < nseg; s++) begin
            len = lcg_range(41);
            eot = (s == nseg - 1);
            pdi_q.push_back({dec ? SEG_CIPHERTEXT : SEG_PLAINTEXT, 2'b00, eot, eot,
                             8'h00, 16'(len)});
            exp_word_q.push_back({dec ? SEG_PLAINTEXT : SEG_CIPHERTEXT, 2'b00, eot,
                                  dec & eot, 8'h00, 16'(len)});
            exp_last_q.push_back(1'b0);
            left = len;
            while (left > 0) begin
                cnt  = (left < BYTES_PER_WORD) ? left : BYTES_PER_WORD;
                w    = rand_word();
                keep = 32'hFFFF_FFFF << (8 * (BYTES_PER_WORD - cnt));
                pdi_q.push_back(w);
                exp_word_q.push_back(w & keep);
                exp_last_q.push_back(1'b0);
                left = left - cnt;
            end
        end
        exp_word_q.push_back({SEG_STATUS_OK, 28'h0});
        exp_last_q.push_back(1'b1);
    end
endtask

`endif

/* verification/tb_lwc_null_wrapper.sv */
/*
 * Random framing test of lwc_null_wrapper, 60 instructions from a fixed LCG seed.
 * Inputs change on the falling edge; outputs are sampled there too.
 */
`default_nettype none

module tb_lwc_null_wrapper
    import lwc_api_pkg::*;
();

    localparam int NUM_INST = 60;

    logic      clk = 1'b0;
    logic      rst;
    lwc_word_t pdi_data;
    logic      pdi_valid;
    logic      pdi_ready;
    lwc_word_t do_data;
    logic      do_valid;
    logic      do_ready;
    logic      do_last;

    int        pdi_idx = 0;
    logic      pdi_sent = 1'b0;
    logic      running = 1'b0;
    logic      stalled = 1'b0;
    lwc_word_t held_data;
    logic      held_last;
    int        cycles = 0;
    int        cycle_limit = 2000;

    `include "tb_lwc_model.svh"

    lwc_null_wrapper #(
        .FIFO_DEPTH (8)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_ready  (do_ready),
        .do_last   (do_last)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lwc_word_t exp, input lwc_word_t act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("ERROR: %s expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    // pdi_ready only changes on the rising edge, so its value now decides the next transfer
    task automatic drive_pdi();
        if (pdi_sent) begin
            pdi_idx++;
            pdi_valid = 1'b0;
        end
        if (!pdi_valid && pdi_idx < pdi_q.size() && lcg_range(4) != 0) begin
            pdi_valid = 1'b1;
            pdi_data  = pdi_q[pdi_idx];
        end
        pdi_sent = pdi_valid && pdi_ready;
    endtask

    task automatic drive_do();
        logic rdy;
        if (stalled) begin
            check_last("do_valid", 1'b1, do_valid);
            check_word("do_data", held_data, do_data);
            check_last("do_last", held_last, do_last);
        end
        rdy      = (lcg_range(10) < 7);
        do_ready = rdy;
        if (do_valid && exp_word_q.size() == 0) begin
            fail_run("DO presented a word while no output was expected");
        end else if (do_valid && rdy) begin
            check_word("do_data", exp_word_q[0], do_data);
            check_last("do_last", exp_last_q[0], do_last);
            void'(exp_word_q.pop_front());
            void'(exp_last_q.pop_front());
        end
        stalled   = do_valid && !rdy;
        held_data = do_data;
        held_last = do_last;
    endtask

    always @(negedge clk) begin
        if (running) begin
            drive_pdi();
            drive_do();
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            fail_run("Timeout: the DUT did not produce all expected output in time");
        end
    end

    initial begin
        rst       = 1'b1;
        pdi_data  = '0;
        pdi_valid = 1'b0;
        do_ready  = 1'b0;
        for (int i = 0; i < NUM_INST; i++) begin
            build_instruction();
        end
        cycle_limit = 20 * pdi_q.size() + 2000;

        repeat (16) begin
            @(negedge clk);
            check_last("do_valid", 1'b0, do_valid);
            check_last("pdi_ready", 1'b0, pdi_ready);
        end
        rst = 1'b0;

        // Idle with no input, nothing may come out
        repeat (8) begin
            @(negedge clk);
            check_last("do_valid", 1'b0, do_valid);
        end

        running = 1'b1;
        while (pdi_idx < pdi_q.size() || exp_word_q.size() != 0) begin
            @(negedge clk);
        end
        // Catch any trailing extra word
        repeat (20) begin
            @(negedge clk);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verification
src/lwc_api_pkg.sv
src/lwc_wrapper_pkg.sv
src/lwc_pdi_parser.sv
src/lwc_entry_fifo.sv
src/lwc_do_formatter.sv
src/lwc_null_wrapper.sv
verification/tb_lwc_null_wrapper.sv
